// File: list.f
+incdir+rtl
rtl/alu_pkg.sv
rtl/alu_operand_if.sv
rtl/add_cmp_unit.sv
rtl/shift_unit.sv
rtl/alu.sv
rtl/alu_wb_top.sv
sim/alu_sva.sv
sim/alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the alu testbench with verilator
rm -f build.log sim.log
verilator --binary --timing --assert -f list.f --top-module alu_tb -o alu_sim > build.log 2>&1 &&
  ./obj_dir/alu_sim > sim.log 2>&1 ||
  echo "SIMULATION FAILED" >> sim.log
cat build.log sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

// File: sim/alu_tb.sv
`timescale 1ns/1ns
`include "alu_defines.svh"

module alu_tb;

  localparam int RAND_OPS       = 300;
  localparam int ACK_WAIT_MAX   = 4;
  localparam int NUM_ACCESSES   = 4000;  // bound over all six tests
  localparam int TIMEOUT_CYCLES = NUM_ACCESSES * ACK_WAIT_MAX + 4000;
  localparam logic [63:0] MIN_NEG  = 64'h8000_0000_0000_0000;
  localparam logic [63:0] ALL_ONES = 64'hffff_ffff_ffff_ffff;

  logic        clk_i;
  logic        rst_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [2:0]  wb_adr_i;
  logic [63:0] wb_dat_i;
  logic [63:0] wb_dat_o;
  logic        wb_ack_o;

  logic [31:0] lcg_state;
  int          cycle_cnt;
  int          check_cnt;
  int          error_cnt;
  int          ack_fail_cnt;
  int          chk_mark;
  int          err_mark;
  int          test_num;

  // pending checks, filled by the tests and drained by the compare process
  string       name_q[$];
  logic [63:0] exp_q[$];
  logic [63:0] got_q[$];

  alu_wb_top i_dut (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  // expected {cmp, result} straight from the rv64 opcode rules
  function automatic logic [64:0] alu_ref(input logic [4:0] op, input logic [63:0] a,
                                          input logic [63:0] b);
    logic [63:0] res;
    logic        cmp;
    logic [5:0]  sh;
    res = '0;
    cmp = 1'b0;
    sh  = b[5:0];
    case (op)
      `ALUOP_ADD:  res = a + b;
      `ALUOP_SUB:  res = a - b;
      `ALUOP_AND:  res = a & b;
      `ALUOP_OR:   res = a | b;
      `ALUOP_XOR:  res = a ^ b;
      `ALUOP_SLL:  res = a << sh;
      `ALUOP_SRL:  res = a >> sh;
      `ALUOP_SRA:  res = $signed(a) >>> sh;
      `ALUOP_SLT,
      `ALUOP_BLT:  cmp = $signed(a) < $signed(b);
      `ALUOP_SLTU,
      `ALUOP_BLTU: cmp = a < b;
      `ALUOP_BEQ:  cmp = (a == b);
      `ALUOP_BNE:  cmp = (a != b);
      `ALUOP_BGE:  cmp = $signed(a) >= $signed(b);
      `ALUOP_BGEU: cmp = a >= b;
      default: ;   // illegal codes give zeros
    endcase
    return {cmp, res};
  endfunction

  // compare process
  always @(posedge clk_i) begin
    string       nm;
    logic [63:0] e;
    logic [63:0] g;
    while (exp_q.size() > 0) begin
      nm = name_q.pop_front();
      e  = exp_q.pop_front();
      g  = got_q.pop_front();
      check_cnt++;
      if (g !== e) begin
        $display("error at %0t ns: %s expected %h got %h", $time, nm, e, g);
        error_cnt++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic queue_check(input string nm, input logic [63:0] e, input logic [63:0] g);
    name_q.push_back(nm);
    exp_q.push_back(e);
    got_q.push_back(g);
  endtask

  // one classic cycle, driven on the falling edge
  task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [63:0] wdat,
                           output logic [63:0] rdat);
    int waited;
    waited = 0;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!wb_ack_o && waited < ACK_WAIT_MAX);
    rdat = wb_dat_o;
    if (!wb_ack_o) begin
      $display("no acknowledge within %0d cycles for address %0d", ACK_WAIT_MAX, adr);
      ack_fail_cnt++;
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [63:0] dat);
    logic [63:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [63:0] dat);
    bus_cycle(1'b0, adr, 64'd0, dat);
  endtask

  task automatic run_op(input logic [4:0] op, input logic [63:0] a, input logic [63:0] b);
    logic [64:0] ref_v;
    logic [63:0] res;
    logic [63:0] cmp;
    ref_v = alu_ref(op, a, b);
    wb_write(`ALU_REG_A, a);
    wb_write(`ALU_REG_B, b);
    wb_write(`ALU_REG_OP, {59'd0, op});
    wb_read(`ALU_REG_RES, res);   // result register already reloaded
    wb_read(`ALU_REG_CMP, cmp);
    queue_check("res", ref_v[63:0], res);
    queue_check("cmp", {63'd0, ref_v[64]}, cmp);
  endtask

  task automatic begin_test();
    test_num++;
    chk_mark = check_cnt;
    err_mark = error_cnt + ack_fail_cnt;
  endtask

  task automatic end_test(input string name);
    @(posedge clk_i);
    @(negedge clk_i);
    $display("test %0d %s: %0d checks, %0d errors", test_num, name, check_cnt - chk_mark,
             error_cnt + ack_fail_cnt - err_mark);
  endtask

  task automatic test_registers();
    logic [63:0] a_pat;
    logic [63:0] b_pat;
    logic [63:0] rd;
    begin_test();
    for (int adr = 0; adr < 5; adr++) begin
      wb_read(adr[2:0], rd);
      queue_check("reset value", 64'd0, rd);
    end
    a_pat = rand64();
    b_pat = rand64();
    wb_write(`ALU_REG_A, a_pat);
    wb_write(`ALU_REG_B, b_pat);
    wb_write(`ALU_REG_OP, 64'hdead_beef_0000_006d);  // only low 5 bits kept
    wb_read(`ALU_REG_A, rd);
    queue_check("reg a", a_pat, rd);
    wb_read(`ALU_REG_B, rd);
    queue_check("reg b", b_pat, rd);
    wb_read(`ALU_REG_OP, rd);
    queue_check("reg op", 64'd13, rd);
    for (int adr = 5; adr < 8; adr++) begin
      wb_write(adr[2:0], ALL_ONES);
      wb_read(adr[2:0], rd);
      queue_check("unmapped", 64'd0, rd);
    end
    end_test("registers");
  endtask

  task automatic test_logic();
    logic [4:0] ops[3];
    begin_test();
    ops[0] = `ALUOP_AND;
    ops[1] = `ALUOP_OR;
    ops[2] = `ALUOP_XOR;
    for (int i = 0; i < 12; i++) begin
      run_op(ops[i % 3], rand64(), rand64());
    end
    run_op(5'd16, rand64(), rand64());
    run_op(5'd31, ALL_ONES, ALL_ONES);
    end_test("logic and illegal");
  endtask

  task automatic test_shifts();
    logic [4:0]  ops[3];
    logic [31:0] r;
    logic [5:0]  sh;
    logic [63:0] a;
    logic [63:0] b;
    begin_test();
    ops[0] = `ALUOP_SLL;
    ops[1] = `ALUOP_SRL;
    ops[2] = `ALUOP_SRA;
    for (int k = 0; k < 6; k++) begin
      r  = lcg_next();
      sh = (k == 0) ? 6'd0 : (k == 1) ? 6'd1 : (k == 2) ? 6'd63 : r[5:0];
      for (int s = 0; s < 2; s++) begin
        a = rand64();
        a = (s == 0) ? (a & ~MIN_NEG) : (a | MIN_NEG);
        b = rand64();
        b[5:0] = sh;   // noise above the shamt field
        for (int o = 0; o < 3; o++) begin
          run_op(ops[o], a, b);
        end
      end
    end
    end_test("shifts");
  endtask

  task automatic test_compares();
    logic [63:0] pa[7];
    logic [63:0] pb[7];
    begin_test();
    pa[0] = rand64();
    pb[0] = pa[0];
    pa[1] = 64'd1;
    pb[1] = MIN_NEG;   // signed and unsigned order disagree
    pa[2] = MIN_NEG;
    pb[2] = 64'd1;
    for (int i = 3; i < 7; i++) begin
      pa[i] = rand64();
      pb[i] = rand64();
    end
    for (int p = 0; p < 7; p++) begin
      for (int op = 8; op < 16; op++) begin
        run_op(op[4:0], pa[p], pb[p]);
      end
    end
    end_test("compares");
  endtask

  task automatic test_random();
    logic [31:0] r;
    logic [63:0] a;
    logic [63:0] b;
    begin_test();
    for (int i = 0; i < RAND_OPS; i++) begin
      r = lcg_next();
      a = rand64();
      b = (r[7:4] == 4'd0) ? a : rand64();  // some equal pairs for beq/bne
      run_op({1'b0, r[3:0]}, a, b);
    end
    end_test("random");
  endtask

  initial begin
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = 3'd0;
    wb_dat_i  = 64'd0;
    rst_i     = 1'b1;
    lcg_state = 32'hb09f;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    test_registers();
    begin_test();
    run_op(`ALUOP_ADD, ALL_ONES, 64'd1);
    run_op(`ALUOP_SUB, MIN_NEG, 64'd1);
    run_op(`ALUOP_SUB, 64'd0, 64'd1);
    run_op(`ALUOP_ADD, MIN_NEG, MIN_NEG);
    end_test("add and sub");
    test_logic();
    test_shifts();
    test_compares();
    test_random();

    $display("tests %0d, checks %0d, errors %0d", test_num, check_cnt,
             error_cnt + ack_fail_cnt);
    if (error_cnt + ack_fail_cnt == 0 && check_cnt > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: sim/alu_sva.sv
`timescale 1ns/1ns

module alu_sva (
  input logic clk_i,
  input logic rst_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o
);

  // ack answers a strobe seen on the previous edge
  ack_needs_stb: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(wb_ack_o) |-> $past(wb_cyc_i && wb_stb_i))
    else $error("ack raised without cyc and stb");

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_ack_o |=> !wb_ack_o)
    else $error("ack held high for two cycles");

  ack_low_after_reset: assert property (@(posedge clk_i)
    rst_i |=> !wb_ack_o)
    else $error("ack high in the cycle after reset");

endmodule

bind alu_wb_top alu_sva i_sva (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .wb_cyc_i (wb_cyc_i),
  .wb_stb_i (wb_stb_i),
  .wb_ack_o (wb_ack_o)
);

// File: rtl/alu_wb_top.sv
`timescale 1ns/1ns
`include "alu_defines.svh"

module alu_wb_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [2:0]           wb_adr_i,
  input  logic [`ALU_XLEN-1:0] wb_dat_i,
  output logic [`ALU_XLEN-1:0] wb_dat_o,
  output logic                 wb_ack_o
);

  logic [`ALU_XLEN-1:0]   a_q;
  logic [`ALU_XLEN-1:0]   b_q;
  logic [`ALU_OP_LEN-1:0] op_q;
  logic [`ALU_XLEN-1:0]   res_q;
  logic                   cmp_q;
  logic                   ack_q;
  logic [`ALU_XLEN-1:0]   rd_q;
  logic [`ALU_XLEN-1:0]   rd_data;
  logic [`ALU_XLEN-1:0]   alu_res;
  logic                   alu_cmp;
  logic                   acc;

  // new access, not yet acknowledged
  assign acc = wb_cyc_i & wb_stb_i & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= acc;  // high for one cycle only
    end
  end

  // operand and opcode registers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_q  <= '0;
      b_q  <= '0;
      op_q <= '0;
    end else if (acc && wb_we_i) begin
      case (wb_adr_i)
        `ALU_REG_A:  a_q  <= wb_dat_i;
        `ALU_REG_B:  b_q  <= wb_dat_i;
        `ALU_REG_OP: op_q <= wb_dat_i[`ALU_OP_LEN-1:0];
        default: ;   // result, compare and holes are read only
      endcase
    end
  end

  alu u_alu (
    .a_i      (a_q),
    .b_i      (b_q),
    .op_i     (op_q),
    .result_o (alu_res),
    .cmp_o    (alu_cmp)
  );

  // outputs trail the operands by one clock
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_q <= '0;
      cmp_q <= 1'b0;
    end else begin
      res_q <= alu_res;
      cmp_q <= alu_cmp;
    end
  end

  always_comb begin
    case (wb_adr_i)
      `ALU_REG_A:   rd_data = a_q;
      `ALU_REG_B:   rd_data = b_q;
      `ALU_REG_OP:  rd_data = {{(`ALU_XLEN-`ALU_OP_LEN){1'b0}}, op_q};
      `ALU_REG_RES: rd_data = res_q;
      `ALU_REG_CMP: rd_data = {{(`ALU_XLEN-1){1'b0}}, cmp_q};
      default:      rd_data = '0;
    endcase
  end

  // read data registered alongside ack
  always_ff @(posedge clk_i) begin
    if (acc) begin
      rd_q <= rd_data;
    end
  end

  assign wb_dat_o = rd_q;
  assign wb_ack_o = ack_q;

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ns
`include "alu_defines.svh"

module alu (
  input  logic [`ALU_XLEN-1:0]   a_i,
  input  logic [`ALU_XLEN-1:0]   b_i,
  input  logic [`ALU_OP_LEN-1:0] op_i,
  output logic [`ALU_XLEN-1:0]   result_o,
  output logic                   cmp_o
);

  alu_operand_if alu_ops ();

  alu_pkg::alu_op_e     op;
  logic [`ALU_XLEN-1:0] sum;
  logic [`ALU_XLEN-1:0] shift_res;

  assign op = alu_pkg::alu_op_e'(op_i);  // illegal codes fall to defaults

  assign alu_ops.a      = a_i;
  assign alu_ops.b.word = b_i;

  // unit control from the opcode
  always_comb begin
    alu_ops.sub_en      = 1'b0;
    alu_ops.shift_en    = 1'b0;
    alu_ops.shift_right = 1'b0;
    alu_ops.shift_arith = 1'b0;
    case (op)
      alu_pkg::OP_SUB, alu_pkg::OP_SLT, alu_pkg::OP_SLTU,
      alu_pkg::OP_BEQ, alu_pkg::OP_BNE, alu_pkg::OP_BLT,
      alu_pkg::OP_BGE, alu_pkg::OP_BLTU, alu_pkg::OP_BGEU: begin
        alu_ops.sub_en = 1'b1;
      end
      alu_pkg::OP_SLL: begin
        alu_ops.shift_en = 1'b1;
      end
      alu_pkg::OP_SRL: begin
        alu_ops.shift_en    = 1'b1;
        alu_ops.shift_right = 1'b1;
      end
      alu_pkg::OP_SRA: begin
        alu_ops.shift_en    = 1'b1;
        alu_ops.shift_right = 1'b1;
        alu_ops.shift_arith = 1'b1;
      end
      default: ;
    endcase
  end

  add_cmp_unit u_add_cmp (
    .ops_i (alu_ops.unit_mp),
    .op_i  (op),
    .sum_o (sum),
    .cmp_o (cmp_o)
  );

  shift_unit u_shift (
    .ops_i   (alu_ops.unit_mp),
    .shift_o (shift_res)
  );

  // final result select
  always_comb begin
    case (op)
      alu_pkg::OP_ADD, alu_pkg::OP_SUB: result_o = sum;
      alu_pkg::OP_SLL, alu_pkg::OP_SRL, alu_pkg::OP_SRA: result_o = shift_res;
      alu_pkg::OP_AND: result_o = a_i & b_i;
      alu_pkg::OP_OR:  result_o = a_i | b_i;
      alu_pkg::OP_XOR: result_o = a_i ^ b_i;
      default:         result_o = '0;  // compares and illegal codes
    endcase
  end

endmodule

// File: rtl/shift_unit.sv
`timescale 1ns/1ns
`include "alu_defines.svh"

module shift_unit (
  alu_operand_if.unit_mp       ops_i,
  output logic [`ALU_XLEN-1:0] shift_o
);

  logic [`ALU_SHAMT_LEN-1:0] shamt;
  logic [`ALU_XLEN-1:0]      a_rev;
  logic [`ALU_XLEN-1:0]      shl_in;
  logic [`ALU_XLEN-1:0]      shl_out;
  logic [`ALU_XLEN-1:0]      srl_res;
  logic [`ALU_XLEN-1:0]      sra_mask;
  logic [`ALU_XLEN-1:0]      sra_res;

  function automatic logic [`ALU_XLEN-1:0] bit_rev(input logic [`ALU_XLEN-1:0] v);
    logic [`ALU_XLEN-1:0] r;
    for (int i = 0; i < `ALU_XLEN; i++) begin
      r[i] = v[`ALU_XLEN-1-i];
    end
    return r;
  endfunction

  assign shamt = ops_i.b.sh.shamt;  // upper bits of b never count

  // a right shift is a left shift of the mirrored word
  assign a_rev   = bit_rev(ops_i.a);
  assign shl_in  = ops_i.shift_right ? a_rev : ops_i.a;
  assign shl_out = shl_in << shamt;
  assign srl_res = bit_rev(shl_out);

  // ones where the shifted data lands, zeros in the vacated top bits
  assign sra_mask = {`ALU_XLEN{1'b1}} >> shamt;
  assign sra_res  = (srl_res & sra_mask) |
                    ({`ALU_XLEN{ops_i.a[`ALU_XLEN-1]}} & ~sra_mask);

  always_comb begin
    if (!ops_i.shift_en) begin
      shift_o = '0;
    end else if (!ops_i.shift_right) begin
      shift_o = shl_out;   // sll
    end else if (ops_i.shift_arith) begin
      shift_o = sra_res;
    end else begin
      shift_o = srl_res;
    end
  end

endmodule

// File: rtl/add_cmp_unit.sv
`timescale 1ns/1ns
`include "alu_defines.svh"

module add_cmp_unit (
  alu_operand_if.unit_mp       ops_i,
  input  alu_pkg::alu_op_e     op_i,
  output logic [`ALU_XLEN-1:0] sum_o,
  output logic                 cmp_o
);

  logic [`ALU_XLEN:0] a_ext;
  logic [`ALU_XLEN:0] b_ext;
  logic [`ALU_XLEN:0] sum_ext;
  logic               zero_f;
  logic               ovf_f;
  logic               sign_f;
  logic               carry_f;
  logic               lt_s;
  logic               lt_u;

  // double sign bit, b inverted when subtracting
  assign a_ext = {ops_i.a[`ALU_XLEN-1], ops_i.a};
  assign b_ext = {ops_i.b.word[`ALU_XLEN-1], ops_i.b.word} ^ {(`ALU_XLEN+1){ops_i.sub_en}};

  // carry-in of one completes the two's complement
  assign sum_ext = a_ext + b_ext + {{`ALU_XLEN{1'b0}}, ops_i.sub_en};

  assign sum_o = sum_ext[`ALU_XLEN-1:0];

  // flags
  assign zero_f = (sum_ext[`ALU_XLEN-1:0] == '0);
  assign ovf_f  = sum_ext[`ALU_XLEN] ^ sum_ext[`ALU_XLEN-1];  // sign bits disagree
  assign sign_f = sum_ext[`ALU_XLEN-1];

  // carry out of bit 63, undone from the guard bit
  assign carry_f = sum_ext[`ALU_XLEN] ^ a_ext[`ALU_XLEN] ^ b_ext[`ALU_XLEN];

  assign lt_s = sign_f ^ ovf_f;         // a < b signed
  assign lt_u = ops_i.sub_en ^ carry_f; // borrow, a < b unsigned

  always_comb begin
    case (op_i)
      alu_pkg::OP_SLT,
      alu_pkg::OP_BLT: begin
        cmp_o = lt_s;
      end
      alu_pkg::OP_SLTU,
      alu_pkg::OP_BLTU: begin
        cmp_o = lt_u;
      end
      alu_pkg::OP_BGE: begin
        cmp_o = ~lt_s;
      end
      alu_pkg::OP_BGEU: begin
        cmp_o = ~lt_u;
      end
      alu_pkg::OP_BEQ: begin
        cmp_o = zero_f;
      end
      alu_pkg::OP_BNE: begin
        cmp_o = ~zero_f;
      end
      default: begin
        cmp_o = 1'b0;  // not a compare
      end
    endcase
  end

endmodule

// File: rtl/alu_operand_if.sv
`timescale 1ns/1ns
`include "alu_defines.svh"

// operands and control from the alu decode to its two units
interface alu_operand_if;

  logic [`ALU_XLEN-1:0]  a;
  alu_pkg::alu_operand_u b;
  logic                  sub_en;       // sub and every compare
  logic                  shift_en;
  logic                  shift_right;
  logic                  shift_arith;  // sign fill, sra only

  modport src_mp (
    output a,
    output b,
    output sub_en,
    output shift_en,
    output shift_right,
    output shift_arith
  );

  modport unit_mp (
    input a,
    input b,
    input sub_en,
    input shift_en,
    input shift_right,
    input shift_arith
  );

endinterface

// File: rtl/alu_pkg.sv
`include "alu_defines.svh"

package alu_pkg;

  typedef enum logic [`ALU_OP_LEN-1:0] {
    OP_ADD  = `ALUOP_ADD,
    OP_XOR  = `ALUOP_XOR,
    OP_OR   = `ALUOP_OR,
    OP_AND  = `ALUOP_AND,
    OP_SLL  = `ALUOP_SLL,
    OP_SRL  = `ALUOP_SRL,
    OP_SRA  = `ALUOP_SRA,
    OP_SUB  = `ALUOP_SUB,
    OP_SLT  = `ALUOP_SLT,
    OP_SLTU = `ALUOP_SLTU,
    OP_BEQ  = `ALUOP_BEQ,
    OP_BNE  = `ALUOP_BNE,
    OP_BLT  = `ALUOP_BLT,
    OP_BGE  = `ALUOP_BGE,
    OP_BLTU = `ALUOP_BLTU,
    OP_BGEU = `ALUOP_BGEU
  } alu_op_e;

  // operand b as seen by the shifter
  typedef struct packed {
    logic [`ALU_XLEN-`ALU_SHAMT_LEN-1:0] rsvd;   // ignored by shifts
    logic [`ALU_SHAMT_LEN-1:0]           shamt;
  } alu_shamt_s;

  typedef union packed {
    logic [`ALU_XLEN-1:0] word;  // data view
    alu_shamt_s           sh;    // shift view
  } alu_operand_u;

endpackage

// File: rtl/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// datapath widths
`define ALU_XLEN      64
`define ALU_OP_LEN    5
`define ALU_SHAMT_LEN 6    // rv64 shift field

// opcode codes
`define ALUOP_ADD  5'd0
`define ALUOP_XOR  5'd1
`define ALUOP_OR   5'd2
`define ALUOP_AND  5'd3
`define ALUOP_SLL  5'd4
`define ALUOP_SRL  5'd5
`define ALUOP_SRA  5'd6
`define ALUOP_SUB  5'd7

// compare group, result word is zero for these
`define ALUOP_SLT  5'd8
`define ALUOP_SLTU 5'd9
`define ALUOP_BEQ  5'd10
`define ALUOP_BNE  5'd11
`define ALUOP_BLT  5'd12
`define ALUOP_BGE  5'd13
`define ALUOP_BLTU 5'd14
`define ALUOP_BGEU 5'd15
// codes 16 to 31 are illegal

// bus register word offsets
`define ALU_REG_A   3'd0
`define ALU_REG_B   3'd1
`define ALU_REG_OP  3'd2
`define ALU_REG_RES 3'd3
`define ALU_REG_CMP 3'd4

`endif
